// File: include/vic_macros.svh
`ifndef VIC_MACROS_SVH
`define VIC_MACROS_SVH

// system clocks per cpu phi period (dot4x / 32)
`define PHI_DIV 32

// clocks per raster line and lines per frame for each chip model
`define RASTER_X_PAL 64
`define RASTER_X_NTSC 65
`define RASTER_Y_PAL 312
`define RASTER_Y_NTSC 263

// sync pulse lengths, hsync in clocks and vsync in lines
`define HSYNC_LEN 6
`define VSYNC_LINES 3

// display window, start inclusive and end exclusive
`define ACTIVE_X_START 12
`define ACTIVE_X_END 52
`define ACTIVE_Y_START 16
`define ACTIVE_Y_END 216

// debug serial link
`define CLKS_PER_BIT 16
`define TX_QUEUE_DEPTH 4

`endif

// File: rtl/vic_video_pkg.sv
package vic_video_pkg;

    // chip model select from the motherboard config pin
    typedef enum logic {
        chip_pal  = 1'b0,
        chip_ntsc = 1'b1
    } chip_t;

    // phi low belongs to the video chip, phi high to the cpu
    typedef enum logic {
        phase_vic = 1'b0,
        phase_cpu = 1'b1
    } phi_phase_t;

    // 4 bits per channel, ordered {r, g, b}
    localparam logic [11:0] palette [0:15] = '{
        12'h000, 12'hFFF, 12'h833, 12'h7CC,
        12'h849, 12'h6A4, 12'h33A, 12'hCD7,
        12'h852, 12'h540, 12'hB66, 12'h444,
        12'h777, 12'hAE8, 12'h77D, 12'hAAA
    };

endpackage

// File: rtl/vic_bus_pkg.sv
package vic_bus_pkg;

    // cpu visible register offsets, only the modelled subset
    typedef enum logic [5:0] {
        reg_ctrl1      = 6'h11,
        reg_raster     = 6'h12,
        reg_irq_status = 6'h19,
        reg_irq_enable = 6'h1A,
        reg_border     = 6'h20
    } reg_addr_t;

    // 8N1 transmitter frame states
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

// File: rtl/vic_regs_if.sv
`timescale 1ns/1ns

// register values down to the raster block, raster status back up
interface vic_regs_if;

    logic [8:0] irq_line;
    logic       irq_enable;
    // single clock pulse, acknowledges the raster interrupt
    logic       irq_clear;
    logic [3:0] border_color;
    logic [8:0] raster_y;
    logic       irq_pending;

    modport regs (
        output irq_line, irq_enable, irq_clear, border_color,
        input  raster_y, irq_pending
    );

    modport timing (
        input  irq_line, irq_enable, irq_clear, border_color,
        output raster_y, irq_pending
    );

endinterface

// File: rtl/phi_gen.sv
`timescale 1ns/1ns

`include "vic_macros.svh"

module phi_gen (
    input  logic                      sys_clock,
    input  logic                      reset,
    output logic                      clk_phi,
    output vic_video_pkg::phi_phase_t phase
);

    localparam int CNT_W = $clog2(`PHI_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PHI_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`PHI_DIV / 2);

    logic [CNT_W-1:0] div_count;

    // free running divider, restarts at 0 on reset
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            div_count <= '0;
        end else if (div_count == CNT_LAST) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // second half of the period is phi high
    assign clk_phi = (div_count >= CNT_HALF);

    // register window only accepts writes in the cpu half
    assign phase = clk_phi ? vic_video_pkg::phase_cpu : vic_video_pkg::phase_vic;

endmodule

// File: rtl/vic_registers.sv
`timescale 1ns/1ns

module vic_registers (
    input  logic                      sys_clock,
    input  logic                      reset,
    input  logic                      ce,
    input  logic                      rw,
    input  logic [5:0]                adi,
    input  logic [7:0]                dbi,
    input  vic_video_pkg::phi_phase_t phase,
    output logic [7:0]                dbo,
    output logic [7:0]                tx_byte,
    output logic                      tx_strobe,
    vic_regs_if.regs                  regs
);

    logic       cpu_write;
    logic       cpu_read;
    logic [7:0] read_value;

    // chip select low, rw low, and only while phi is high
    assign cpu_write = !ce && !rw && (phase == vic_video_pkg::phase_cpu);
    // reads do not care about the phase
    assign cpu_read = !ce && rw;

    // write decode
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            regs.irq_line     <= '0;
            regs.irq_enable   <= 1'b0;
            regs.border_color <= '0;
        end else if (cpu_write) begin
            case (adi)
                // compare line bit 8 lives in ctrl1 bit 7
                vic_bus_pkg::reg_ctrl1:      regs.irq_line[8] <= dbi[7];
                vic_bus_pkg::reg_raster:     regs.irq_line[7:0] <= dbi;
                vic_bus_pkg::reg_irq_enable: regs.irq_enable <= dbi[0];
                vic_bus_pkg::reg_border:     regs.border_color <= dbi[3:0];
                default: ;
            endcase
        end
    end

    // writing a 1 to status bit 0 acks the raster irq on this same edge
    assign regs.irq_clear = cpu_write && (adi == vic_bus_pkg::reg_irq_status) && dbi[0];

    // read-back mux, unused bits read as 1 like the real part
    always_comb begin
        case (adi)
            vic_bus_pkg::reg_ctrl1:      read_value = {regs.raster_y[8], 7'b0};
            vic_bus_pkg::reg_raster:     read_value = regs.raster_y[7:0];
            vic_bus_pkg::reg_irq_status: read_value = {7'h7F, regs.irq_pending};
            vic_bus_pkg::reg_irq_enable: read_value = {7'h7F, regs.irq_enable};
            vic_bus_pkg::reg_border:     read_value = {4'hF, regs.border_color};
            default:                     read_value = 8'hFF;
        endcase
    end

    // data out is latched on a read and held until the next one
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            dbo <= 8'hFF;
        end else if (cpu_read) begin
            dbo <= read_value;
        end
    end

    // every write also goes out as a debug byte
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            tx_strobe <= 1'b0;
        end else begin
            tx_strobe <= cpu_write;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (cpu_write) begin
            tx_byte <= dbi;
        end
    end

endmodule

// File: rtl/raster_timing.sv
`timescale 1ns/1ns

`include "vic_macros.svh"

module raster_timing (
    input  logic                 sys_clock,
    input  logic                 reset,
    input  vic_video_pkg::chip_t chip,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 active,
    output logic [3:0]           red,
    output logic [3:0]           green,
    output logic [3:0]           blue,
    output logic                 irq,
    vic_regs_if.timing           regs
);

    localparam logic [6:0] X_LAST_PAL  = 7'(`RASTER_X_PAL - 1);
    localparam logic [6:0] X_LAST_NTSC = 7'(`RASTER_X_NTSC - 1);
    localparam logic [8:0] Y_LAST_PAL  = 9'(`RASTER_Y_PAL - 1);
    localparam logic [8:0] Y_LAST_NTSC = 9'(`RASTER_Y_NTSC - 1);
    localparam logic [6:0] HSYNC_END   = 7'(`HSYNC_LEN);
    localparam logic [8:0] VSYNC_END   = 9'(`VSYNC_LINES);
    localparam logic [6:0] X_START     = 7'(`ACTIVE_X_START);
    localparam logic [6:0] X_END       = 7'(`ACTIVE_X_END);
    localparam logic [8:0] Y_START     = 9'(`ACTIVE_Y_START);
    localparam logic [8:0] Y_END       = 9'(`ACTIVE_Y_END);

    logic [6:0] raster_x;
    logic [8:0] raster_y;
    logic [6:0] x_last;
    logic [8:0] y_last;
    logic       in_window;

    // ntsc has one extra clock per line and far fewer lines
    assign x_last = (chip == vic_video_pkg::chip_ntsc) ? X_LAST_NTSC : X_LAST_PAL;
    assign y_last = (chip == vic_video_pkg::chip_ntsc) ? Y_LAST_NTSC : Y_LAST_PAL;

    // x every clock, y on the x wrap
    // >= so a chip switch mid line cannot run past the end
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (raster_x >= x_last) begin
            raster_x <= '0;
            if (raster_y >= y_last) begin
                raster_y <= '0;
            end else begin
                raster_y <= raster_y + 1'b1;
            end
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

    assign regs.raster_y = raster_y;

    assign in_window = (raster_x >= X_START) && (raster_x < X_END) &&
                       (raster_y >= Y_START) && (raster_y < Y_END);

    // video outputs, one clock behind the counters
    always_ff @(posedge sys_clock) begin
        hsync  <= (raster_x < HSYNC_END);
        vsync  <= (raster_y < VSYNC_END);
        active <= in_window;
        // border only, the display window itself is left black
        if (in_window) begin
            {red, green, blue} <= 12'h000;
        end else begin
            {red, green, blue} <= vic_video_pkg::palette[regs.border_color];
        end
    end

    // raster compare fires once per line at x 0
    // set wins over an ack in the same clock
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            regs.irq_pending <= 1'b0;
        end else if (raster_x == '0 && raster_y == regs.irq_line) begin
            regs.irq_pending <= 1'b1;
        end else if (regs.irq_clear) begin
            regs.irq_pending <= 1'b0;
        end
    end

    assign irq = regs.irq_pending && regs.irq_enable;

endmodule

// File: rtl/serial_tx.sv
`timescale 1ns/1ns

`include "vic_macros.svh"

module serial_tx (
    input  logic       sys_clock,
    input  logic       reset,
    input  logic [7:0] tx_byte,
    input  logic       tx_strobe,
    output logic       tx
);

    localparam int PTR_W = $clog2(`TX_QUEUE_DEPTH);
    localparam int TMR_W = $clog2(`CLKS_PER_BIT);
    localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`CLKS_PER_BIT - 1);
    localparam logic [PTR_W:0] QUEUE_FULL = (PTR_W + 1)'(`TX_QUEUE_DEPTH);

    logic [7:0]           queue [0:`TX_QUEUE_DEPTH-1];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;
    logic                 push;
    logic                 pop;
    logic                 bit_end;
    vic_bus_pkg::tx_state_t state;
    logic [TMR_W-1:0]     timer;
    logic [2:0]           bit_idx;
    logic [7:0]           shifter;

    // drop the byte when full, even if a pop happens the same clock
    assign push = tx_strobe && (count != QUEUE_FULL);
    assign bit_end = (timer == TMR_LAST);
    // take the next byte from idle or straight out of a stop bit
    assign pop = (count != '0) &&
                 ((state == vic_bus_pkg::tx_idle) ||
                  (state == vic_bus_pkg::tx_stop && bit_end));

    always_ff @(posedge sys_clock) begin
        if (push) begin
            queue[wr_ptr] <= tx_byte;
        end
    end

    // circular pointers, count tracks occupancy
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    // frame fsm, line idles high
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            state   <= vic_bus_pkg::tx_idle;
            tx      <= 1'b1;
            timer   <= '0;
            bit_idx <= '0;
        end else begin
            timer <= bit_end ? '0 : timer + 1'b1;
            if (pop) begin
                // start bit, back to back with any previous stop bit
                state   <= vic_bus_pkg::tx_start;
                tx      <= 1'b0;
                timer   <= '0;
                shifter <= queue[rd_ptr];
            end else begin
                case (state)
                    vic_bus_pkg::tx_idle: begin
                        tx    <= 1'b1;
                        timer <= '0;
                    end
                    vic_bus_pkg::tx_start: if (bit_end) begin
                        state   <= vic_bus_pkg::tx_data;
                        tx      <= shifter[0];
                        bit_idx <= '0;
                    end
                    vic_bus_pkg::tx_data: if (bit_end) begin
                        // lsb first
                        if (bit_idx == 3'd7) begin
                            state <= vic_bus_pkg::tx_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            shifter <= shifter >> 1;
                            tx      <= shifter[1];
                        end
                    end
                    vic_bus_pkg::tx_stop: if (bit_end) begin
                        state <= vic_bus_pkg::tx_idle;
                    end
                    default: state <= vic_bus_pkg::tx_idle;
                endcase
            end
        end
    end

endmodule

// File: rtl/vic_top.sv
`timescale 1ns/1ns

module vic_top (
    input  logic                 sys_clock,
    input  logic                 reset,
    input  vic_video_pkg::chip_t chip,
    input  logic                 ce,
    input  logic                 rw,
    input  logic [5:0]           adi,
    input  logic [7:0]           dbi,
    output logic [7:0]           dbo,
    output logic                 irq,
    output logic                 clk_phi,
    output logic                 cpu_reset,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 active,
    output logic [3:0]           red,
    output logic [3:0]           green,
    output logic [3:0]           blue,
    output logic                 tx
);

    vic_video_pkg::phi_phase_t phase;
    logic [7:0]                tx_byte;
    logic                      tx_strobe;

    vic_regs_if regs_bus ();

    // cpu is held in reset together with the chip
    assign cpu_reset = reset;

    phi_gen phi_gen_inst (
        .sys_clock (sys_clock),
        .reset     (reset),
        .clk_phi   (clk_phi),
        .phase     (phase)
    );

    vic_registers vic_registers_inst (
        .sys_clock (sys_clock),
        .reset     (reset),
        .ce        (ce),
        .rw        (rw),
        .adi       (adi),
        .dbi       (dbi),
        .phase     (phase),
        .dbo       (dbo),
        .tx_byte   (tx_byte),
        .tx_strobe (tx_strobe),
        .regs      (regs_bus.regs)
    );

    raster_timing raster_timing_inst (
        .sys_clock (sys_clock),
        .reset     (reset),
        .chip      (chip),
        .hsync     (hsync),
        .vsync     (vsync),
        .active    (active),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .irq       (irq),
        .regs      (regs_bus.timing)
    );

    // debug stream of every register write
    serial_tx serial_tx_inst (
        .sys_clock (sys_clock),
        .reset     (reset),
        .tx_byte   (tx_byte),
        .tx_strobe (tx_strobe),
        .tx        (tx)
    );

endmodule

// File: verification/vic_assert.sv
`timescale 1ns/1ns

module vic_assert (
    input logic       sys_clock,
    input logic       reset,
    input logic       ce,
    input logic       rw,
    input logic [5:0] adi,
    input logic [7:0] dbi,
    input logic       tx,
    input logic       irq,
    input logic       clk_phi,
    input logic       active,
    input logic [3:0] red,
    input logic [3:0] green,
    input logic [3:0] blue
);

    logic       last_phi;
    logic [5:0] run;
    logic       seen_change;
    logic       cpu_write;
    logic       en_shadow;
    logic [3:0] border_shadow;

    // phi high is the cpu half, the only half that takes writes
    assign cpu_write = !ce && !rw && clk_phi;

    // enable and border colour as the cpu wrote them on the pins
    always_ff @(posedge sys_clock) begin
        if (reset) begin
            en_shadow     <= 1'b0;
            border_shadow <= '0;
        end else if (cpu_write) begin
            if (adi == vic_bus_pkg::reg_irq_enable) en_shadow <= dbi[0];
            if (adi == vic_bus_pkg::reg_border) border_shadow <= dbi[3:0];
        end
    end

    // clocks since the last phi edge, first edge after reset is not timed
    always_ff @(posedge sys_clock) begin
        last_phi <= clk_phi;
        if (reset) begin
            run         <= '0;
            seen_change <= 1'b0;
        end else if (clk_phi != last_phi) begin
            run         <= 6'd1;
            seen_change <= 1'b1;
        end else begin
            run <= run + 1'b1;
        end
    end

    a_tx_idle_in_reset: assert property (@(posedge sys_clock) reset && $past(reset) |-> tx)
        else $error("serial line low during reset");

    a_irq_needs_enable: assert property (@(posedge sys_clock) disable iff (reset)
        $rose(irq) |-> en_shadow)
        else $error("irq rose with interrupts disabled");

    // half period of phi is 16 system clocks
    a_phi_half_period: assert property (@(posedge sys_clock) disable iff (reset)
        (clk_phi != last_phi) && seen_change |-> run == 6'd16)
        else $error("phi edge spacing wrong");

    // black inside the window, border colour one clock after the write lands
    a_pixel_colour: assert property (@(posedge sys_clock) disable iff (reset)
        {red, green, blue} ==
            (active ? 12'h000 : vic_video_pkg::palette[$past(border_shadow)]))
        else $error("pixel colour differs from the window and border rule");

endmodule

bind vic_top vic_assert vic_assert_inst (
    .sys_clock  (sys_clock),
    .reset      (reset),
    .ce         (ce),
    .rw         (rw),
    .adi        (adi),
    .dbi        (dbi),
    .tx         (tx),
    .irq        (irq),
    .clk_phi    (clk_phi),
    .active     (active),
    .red        (red),
    .green      (green),
    .blue       (blue)
);

// File: verification/vic_tb.sv
`timescale 1ns/1ns

`include "vic_macros.svh"

module vic_tb;

    localparam int FRAME_PAL = `RASTER_X_PAL * `RASTER_Y_PAL;
    localparam int FRAME_NTSC = `RASTER_X_NTSC * `RASTER_Y_NTSC;
    // raster tests take two frames, irq waits up to four, the rest is short
    localparam int RUN_CLOCKS = 2 * FRAME_PAL + 4 * FRAME_PAL + 20000;
    localparam int FRAME_CLKS = 10 * `CLKS_PER_BIT;

    logic sys_clock = 1'b0;
    logic reset;
    vic_video_pkg::chip_t chip;
    logic ce;
    logic rw;
    logic [5:0] adi;
    logic [7:0] dbi;
    logic [7:0] dbo;
    logic irq, clk_phi, cpu_reset, hsync, vsync, active, tx;
    logic [3:0] red, green, blue;

    integer seed = 11790;
    bit checking = 0;
    // reference model state
    int phi_cnt, rx, ry, q_cnt, frame_left, drops, x_len, y_len;
    int rx_bytes = 0;
    logic [8:0] m_line;
    logic m_en, m_pend, e_hsync, e_vsync, e_active, strobe_d, wr, rd, clr, win;
    logic [3:0] m_border;
    logic [11:0] e_rgb;
    logic [7:0] e_dbo, strobe_byte;
    logic [7:0] exp_bytes[$];
    bit dec_busy = 0;
    logic [5:0] addr_pool[6] = '{6'h11, 6'h12, 6'h19, 6'h1A, 6'h20, 6'h3F};

    vic_top uut (.*);

    always #50 sys_clock = ~sys_clock;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] read_rule(input logic [5:0] a);
        case (a)
            6'h11: return {ry[8], 7'b0};
            6'h12: return ry[7:0];
            6'h19: return {7'h7F, m_pend};
            6'h1A: return {7'h7F, m_en};
            6'h20: return {4'hF, m_border};
            default: return 8'hFF;
        endcase
    endfunction

    // model steps on the same edge as the dut, from pre-edge values
    always @(posedge sys_clock) begin
        if (reset) begin
            phi_cnt = 0;
            rx = 0;
            ry = 0;
            m_line = '0;
            m_en = 0;
            m_border = '0;
            m_pend = 0;
            e_dbo = 8'hFF;
            strobe_d = 0;
            q_cnt = 0;
            frame_left = 0;
            drops = 0;
            exp_bytes.delete();
        end else begin
            wr = !ce && !rw && (phi_cnt >= `PHI_DIV / 2);
            rd = !ce && rw;
            win = rx >= `ACTIVE_X_START && rx < `ACTIVE_X_END &&
                  ry >= `ACTIVE_Y_START && ry < `ACTIVE_Y_END;
            e_hsync = rx < `HSYNC_LEN;
            e_vsync = ry < `VSYNC_LINES;
            e_active = win;
            e_rgb = win ? 12'h000 : vic_video_pkg::palette[m_border];
            if (rd) e_dbo = read_rule(adi);
            clr = wr && adi == 6'h19 && dbi[0];
            // set beats clear
            if (rx == 0 && ry == m_line) m_pend = 1;
            else if (clr) m_pend = 0;
            // queue occupancy and frame timer of the serial path
            if (strobe_d && q_cnt == `TX_QUEUE_DEPTH) drops++;
            if (strobe_d && q_cnt != `TX_QUEUE_DEPTH) begin
                exp_bytes.push_back(strobe_byte);
                q_cnt++;
                if (q_cnt - 1 != 0 && frame_left <= 1) begin
                    q_cnt--;
                    frame_left = FRAME_CLKS;
                end else if (frame_left > 0) frame_left--;
            end else if (q_cnt != 0 && frame_left <= 1) begin
                q_cnt--;
                frame_left = FRAME_CLKS;
            end else if (frame_left > 0) frame_left--;
            strobe_d = wr;
            strobe_byte = dbi;
            if (wr) begin
                case (adi)
                    6'h11: m_line[8] = dbi[7];
                    6'h12: m_line[7:0] = dbi;
                    6'h1A: m_en = dbi[0];
                    6'h20: m_border = dbi[3:0];
                    default: ;
                endcase
            end
            // line length and frame height of the selected chip
            x_len = (chip == vic_video_pkg::chip_ntsc) ? `RASTER_X_NTSC : `RASTER_X_PAL;
            y_len = (chip == vic_video_pkg::chip_ntsc) ? `RASTER_Y_NTSC : `RASTER_Y_PAL;
            if (rx >= x_len - 1) begin
                rx = 0;
                if (ry >= y_len - 1) ry = 0;
                else ry++;
            end else rx++;
            phi_cnt = (phi_cnt + 1) % `PHI_DIV;
        end
    end

    // outputs are compared between edges where they are settled
    always @(negedge sys_clock) begin
        if (checking) begin
            check("phi", phi_cnt >= `PHI_DIV / 2, clk_phi);
            check("hsync", e_hsync, hsync);
            check("vsync", e_vsync, vsync);
            check("active", e_active, active);
            check("rgb", e_rgb, {red, green, blue});
            check("dbo", e_dbo, dbo);
            check("irq", m_pend && m_en, irq);
            check("cpu_reset", reset, cpu_reset);
        end
    end

    // serial decoder, samples the middle of each bit
    initial begin
        logic [7:0] got;
        forever begin
            @(negedge sys_clock);
            if (checking && tx === 1'b0) begin
                dec_busy = 1;
                repeat (`CLKS_PER_BIT / 2) @(negedge sys_clock);
                check("start_bit", 0, tx);
                for (int i = 0; i < 8; i++) begin
                    repeat (`CLKS_PER_BIT) @(negedge sys_clock);
                    got[i] = tx;
                end
                repeat (`CLKS_PER_BIT) @(negedge sys_clock);
                check("stop_bit", 1, tx);
                if (exp_bytes.size() == 0) begin
                    $display("serial byte %0h arrived but none was expected", got);
                    $display("TEST FAIL");
                    $fatal(1);
                end
                check("serial_byte", exp_bytes.pop_front(), got);
                rx_bytes++;
                dec_busy = 0;
            end
        end
    end

    // waits for the clock whose edge the dut sees in the wanted phase
    task automatic bus_write(input logic [5:0] a, input logic [7:0] d, input bit cpu);
        do @(negedge sys_clock);
        while ((((phi_cnt + 1) % `PHI_DIV) >= `PHI_DIV / 2) != cpu);
        @(posedge sys_clock);
        ce <= 0;
        rw <= 0;
        adi <= a;
        dbi <= d;
        @(posedge sys_clock);
        ce <= 1;
        rw <= 1;
    endtask

    task automatic bus_read(input logic [5:0] a);
        @(posedge sys_clock);
        ce <= 0;
        rw <= 1;
        adi <= a;
        @(posedge sys_clock);
        ce <= 1;
        @(negedge sys_clock);
    endtask

    task automatic wait_pending(input string what);
        int n;
        n = 0;
        while (!m_pend) begin
            @(negedge sys_clock);
            n++;
            if (n > 2 * FRAME_PAL) begin
                $display("raster interrupt never became pending during %s", what);
                $display("TEST FAIL");
                $fatal(1);
            end
        end
    endtask

    task automatic wait_serial_idle();
        do @(negedge sys_clock);
        while (q_cnt != 0 || frame_left != 0 || strobe_d || dec_busy);
    endtask

    initial begin
        int drops_before, bytes_before;
        logic [8:0] line;
        reset = 1;
        chip = vic_video_pkg::chip_pal;
        ce = 1;
        rw = 1;
        adi = '0;
        dbi = '0;
        @(posedge sys_clock);
        @(negedge sys_clock);
        check("reset_tx", 1, tx);
        check("reset_irq", 0, irq);
        check("reset_cpu", 1, cpu_reset);
        check("reset_dbo", 8'hFF, dbo);
        @(posedge sys_clock);
        reset <= 0;
        @(posedge sys_clock);
        checking <= 1;
        // full frame per chip model with random border colours
        repeat (20) begin
            repeat (1000) @(posedge sys_clock);
            bus_write(6'h20, $random(seed), 1);
        end
        chip <= vic_video_pkg::chip_ntsc;
        repeat (18) begin
            repeat (1000) @(posedge sys_clock);
            bus_write(6'h20, $random(seed), 1);
        end
        // register read-back, vic phase writes must be ignored
        repeat (40) begin
            bus_write(addr_pool[$unsigned($random(seed)) % 6], $random(seed), $random(seed) & 1);
            bus_read(addr_pool[$unsigned($random(seed)) % 6]);
        end
        // raster interrupt, enabled pass
        line = $unsigned($random(seed)) % `RASTER_Y_NTSC;
        bus_write(6'h11, {line[8], 7'b0}, 1);
        bus_write(6'h12, line[7:0], 1);
        bus_write(6'h19, 8'h01, 1);
        bus_write(6'h1A, 8'h01, 1);
        wait_pending("enabled pass");
        @(negedge sys_clock);
        check("irq_set", 1, irq);
        // still on the compare line a few clocks after x 0
        bus_read(6'h12);
        check("irq_line_lo", line[7:0], dbo);
        bus_read(6'h11);
        check("irq_line_hi", {line[8], 7'b0}, dbo);
        bus_write(6'h19, 8'h01, 1);
        @(negedge sys_clock);
        check("irq_cleared", 0, irq);
        // disabled pass
        bus_write(6'h1A, 8'h00, 1);
        bus_write(6'h19, 8'h01, 1);
        wait_pending("disabled pass");
        check("irq_masked", 0, irq);
        bus_read(6'h19);
        check("status_pending", 8'hFF, dbo);
        // burst of six writes into the four deep queue
        wait_serial_idle();
        drops_before = drops;
        bytes_before = rx_bytes;
        do @(negedge sys_clock);
        while ((((phi_cnt + 1) % `PHI_DIV) >= `PHI_DIV / 2) != 1);
        repeat (6) begin
            @(posedge sys_clock);
            ce <= 0;
            rw <= 0;
            adi <= 6'h20;
            dbi <= $random(seed);
            @(posedge sys_clock);
            ce <= 1;
            rw <= 1;
            repeat (30) @(posedge sys_clock);
        end
        wait_serial_idle();
        check("burst_drops", 1, drops - drops_before);
        check("burst_bytes", 5, rx_bytes - bytes_before);
        check("bytes_left", 0, exp_bytes.size());
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(longint'(RUN_CLOCKS) * 100);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $fatal(1);
    end

endmodule

// File: compile.f
+incdir+include
rtl/vic_video_pkg.sv
rtl/vic_bus_pkg.sv
rtl/vic_regs_if.sv
rtl/phi_gen.sv
rtl/vic_registers.sv
rtl/raster_timing.sv
rtl/serial_tx.sv
rtl/vic_top.sv
verification/vic_assert.sv
verification/vic_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := vic_tb
FILELIST  := compile.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv verification/*.sv include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)
